// File: verilog/lsc_pkg.sv
// shared types and constants for the vector load-store path
// every module refers to these through lsc_pkg:: scoped names
`default_nettype none

package lsc_pkg;

    // geometry
    localparam int NUM_LANES        = 4;
    localparam int BLOCK_WORDS      = 4;
    localparam int N_BLOCK_BITS     = 2;
    localparam int MEM_BLOCKS       = 16;
    localparam int BLOCK_INDEX_BITS = $clog2(MEM_BLOCKS);

    // timing of the memory model
    localparam int MEM_LATENCY    = 2;
    localparam int IFLUSH_CYCLES  = 2;
    localparam int DFLUSH_CYCLES  = 6;
    localparam int MEM_CNT_BITS   = $clog2(MEM_LATENCY + 1);
    localparam int FLUSH_CNT_BITS = $clog2(DFLUSH_CYCLES + 1);

    // 1 = big-endian byte order on the bus
    localparam bit BUS_BIG_ENDIAN = 1'b0;

    typedef logic [31:0] word_t;
    typedef word_t [BLOCK_WORDS-1:0] block_t;
    typedef word_t [NUM_LANES-1:0] lane_words_t;

    typedef enum logic [2:0] {LB, LBU, LH, LHU, LW} load_type_e;

    typedef struct packed {
        logic                 ren;
        logic                 wen;
        load_type_e           load_type;
        logic                 block_access;
        word_t                addr;
        word_t                store_data;
        lane_words_t          store_data_wide;
        lane_words_t          addr_wide;
        logic [NUM_LANES-1:0] ven_lanes;
    } lsc_req_t;

    typedef struct packed {
        logic        ready;
        logic        mal_addr;
        word_t       dload_ext;
        lane_words_t dload_ext_wide;
    } lsc_resp_t;

    typedef struct packed {
        logic                     ren;
        logic                     wen;
        word_t                    addr;
        logic [4*BLOCK_WORDS-1:0] byte_en;
        block_t                   wdata;
    } bus_req_t;

    typedef struct packed {
        logic icache_flush;
        logic dcache_flush;
    } cache_ctl_t;

    // reverse byte order of one word
    function automatic word_t byte_swap(word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

`default_nettype wire

// File: verilog/lsc_req_latch.sv
// input register for core requests
// captures a new request only while the path is ready, else holds it
`timescale 1ns/10ps
`default_nettype none

module lsc_req_latch (
    input  wire logic             CLK,
    input  wire logic             nRST,
    input  wire lsc_pkg::lsc_req_t core_req,
    input  wire logic             ready,
    output lsc_pkg::lsc_req_t     held_req
);

    logic              ren_q;
    logic              wen_q;
    lsc_pkg::lsc_req_t payload_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end else if (ready) begin
            ren_q <= core_req.ren;
            wen_q <= core_req.wen;
        end
    end

    // address and data fields
    always_ff @(posedge CLK) begin
        if (ready) begin
            payload_q <= core_req;
        end
    end

    always_comb begin
        held_req     = payload_q;
        held_req.ren = ren_q;
        held_req.wen = wen_q;
    end

endmodule

`default_nettype wire

// File: verilog/lsc_byte_lane.sv
// byte enable and alignment check for one 32-bit access
// used once for scalar accesses and once per vector lane
`timescale 1ns/10ps
`default_nettype none

module lsc_byte_lane (
    input  wire lsc_pkg::word_t      addr,
    input  wire lsc_pkg::load_type_e load_type,
    input  wire logic                is_store,
    output logic [3:0]               byte_en,
    output logic                     mal_addr
);

    logic [1:0] offset;
    logic [3:0] be_std;

    assign offset = addr[1:0];

    always_comb begin
        be_std   = 4'b0000;
        mal_addr = 1'b0;
        case (load_type)
            lsc_pkg::LB, lsc_pkg::LBU: begin
                be_std = 4'b0001 << offset;
            end
            lsc_pkg::LH, lsc_pkg::LHU: begin
                // only offsets 0 and 2 map to a valid half
                case (offset)
                    2'b00:   be_std = 4'b0011;
                    2'b10:   be_std = 4'b1100;
                    default: be_std = 4'b0000;
                endcase
                mal_addr = offset[0];
            end
            lsc_pkg::LW: begin
                be_std   = 4'b1111;
                mal_addr = (offset != 2'b00);
            end
            default: begin
                be_std   = 4'b0000;
                mal_addr = 1'b0;
            end
        endcase
    end

    // store enables follow the swapped data on a big-endian bus
    assign byte_en = (lsc_pkg::BUS_BIG_ENDIAN && is_store)
                   ? {be_std[0], be_std[1], be_std[2], be_std[3]}
                   : be_std;

endmodule

`default_nettype wire

// File: verilog/lsc_load_extend.sv
// load data extension
// moves the enabled byte or half to bit 0, then sign or zero extends
`timescale 1ns/10ps
`default_nettype none

module lsc_load_extend (
    input  wire lsc_pkg::word_t      word_in,
    input  wire lsc_pkg::load_type_e load_type,
    input  wire logic [3:0]          byte_en,
    output lsc_pkg::word_t           ext_out
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    always_comb begin
        case (byte_en)
            4'b0001: sel_byte = word_in[7:0];
            4'b0010: sel_byte = word_in[15:8];
            4'b0100: sel_byte = word_in[23:16];
            4'b1000: sel_byte = word_in[31:24];
            default: sel_byte = 8'h00;
        endcase
        case (byte_en)
            4'b0011: sel_half = word_in[15:0];
            4'b1100: sel_half = word_in[31:16];
            default: sel_half = 16'h0000;
        endcase
    end

    always_comb begin
        case (load_type)
            lsc_pkg::LB:  ext_out = {{24{sel_byte[7]}}, sel_byte};
            lsc_pkg::LBU: ext_out = {24'h000000, sel_byte};
            lsc_pkg::LH:  ext_out = {{16{sel_half[15]}}, sel_half};
            lsc_pkg::LHU: ext_out = {16'h0000, sel_half};
            lsc_pkg::LW:  ext_out = word_in;
            default:      ext_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/lsc_fence_tracker.sv
// instruction fence handling
// a rising ifence flushes both caches, stall holds until both report done
`timescale 1ns/10ps
`default_nettype none

module lsc_fence_tracker (
    input  wire logic        CLK,
    input  wire logic        nRST,
    input  wire logic        ifence,
    input  wire logic        iflush_done,
    input  wire logic        dflush_done,
    output lsc_pkg::cache_ctl_t cc,
    output logic             fence_stall
);

    logic ifence_d;
    logic fence_pulse;
    logic iflushed;
    logic dflushed;

    assign fence_pulse = ifence & ~ifence_d;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_d <= 1'b0;
            iflushed <= 1'b1;
            dflushed <= 1'b1;
        end else begin
            ifence_d <= ifence;
            // a done pulse wins over a new fence in the same cycle
            if (iflush_done) begin
                iflushed <= 1'b1;
            end else if (fence_pulse) begin
                iflushed <= 1'b0;
            end
            if (dflush_done) begin
                dflushed <= 1'b1;
            end else if (fence_pulse) begin
                dflushed <= 1'b0;
            end
        end
    end

    assign cc.icache_flush = fence_pulse;
    assign cc.dcache_flush = fence_pulse;

    assign fence_stall = ~(iflushed & dflushed);

endmodule

`default_nettype wire

// File: verilog/load_store_controller.sv
// load-store controller for scalar and four-lane block accesses
// turns the held core request into a block-wide bus request and extends
// the returned block data into scalar and per-lane load results
`timescale 1ns/10ps
`default_nettype none

module load_store_controller (
    input  wire lsc_pkg::lsc_req_t held_req,
    input  wire lsc_pkg::block_t   rdata,
    input  wire logic              busy,
    output lsc_pkg::bus_req_t      bus_req,
    output lsc_pkg::lsc_resp_t     core_resp
);

    logic [3:0]                       be_scalar;
    logic                             mal_scalar;
    logic [lsc_pkg::N_BLOCK_BITS-1:0] slot;
    lsc_pkg::word_t                   store_repl;
    lsc_pkg::block_t                  rd_words;
    logic [lsc_pkg::NUM_LANES-1:0][3:0] be_lane;
    lsc_pkg::lane_words_t             lane_word;

    // word slot of a scalar access inside its block
    assign slot = held_req.addr[2 +: lsc_pkg::N_BLOCK_BITS];

    lsc_byte_lane u_scalar_lane (
        .addr      (held_req.addr),
        .load_type (held_req.load_type),
        .is_store  (held_req.wen),
        .byte_en   (be_scalar),
        .mal_addr  (mal_scalar)
    );

    // store data replicated so each byte lane sees it
    always_comb begin
        case (held_req.load_type)
            lsc_pkg::LB, lsc_pkg::LBU: store_repl = {4{held_req.store_data[7:0]}};
            lsc_pkg::LH, lsc_pkg::LHU: store_repl = {2{held_req.store_data[15:0]}};
            lsc_pkg::LW:               store_repl = held_req.store_data;
            default:                   store_repl = '0;
        endcase
    end

    assign bus_req.ren = held_req.ren;
    assign bus_req.wen = held_req.wen;

    always_comb begin
        if (held_req.block_access) begin
            bus_req.addr = {held_req.addr[31:lsc_pkg::N_BLOCK_BITS+2],
                            (lsc_pkg::N_BLOCK_BITS+2)'(0)};
            for (int i = 0; i < lsc_pkg::BLOCK_WORDS; i++) begin
                bus_req.byte_en[4*i +: 4] = held_req.ven_lanes[i] ? 4'hf : 4'h0;
                bus_req.wdata[i] = lsc_pkg::BUS_BIG_ENDIAN
                                 ? lsc_pkg::byte_swap(held_req.store_data_wide[i])
                                 : held_req.store_data_wide[i];
            end
        end else begin
            bus_req.addr    = held_req.addr;
            bus_req.byte_en = (4*lsc_pkg::BLOCK_WORDS)'(be_scalar) << (4 * slot);
            for (int i = 0; i < lsc_pkg::BLOCK_WORDS; i++) begin
                bus_req.wdata[i] = lsc_pkg::BUS_BIG_ENDIAN
                                 ? lsc_pkg::byte_swap(store_repl)
                                 : store_repl;
            end
        end
    end

    // back to core byte order
    always_comb begin
        for (int i = 0; i < lsc_pkg::BLOCK_WORDS; i++) begin
            rd_words[i] = lsc_pkg::BUS_BIG_ENDIAN ? lsc_pkg::byte_swap(rdata[i]) : rdata[i];
        end
    end

    lsc_load_extend u_scalar_ext (
        .word_in   (rd_words[slot]),
        .load_type (held_req.load_type),
        .byte_en   (be_scalar),
        .ext_out   (core_resp.dload_ext)
    );

    for (genvar g = 0; g < lsc_pkg::NUM_LANES; g++) begin : g_lane
        lsc_byte_lane u_lane (
            .addr      (held_req.addr_wide[g]),
            .load_type (held_req.load_type),
            .is_store  (1'b0),
            .byte_en   (be_lane[g]),
            .mal_addr  ()
        );

        // each enabled lane picks its own word of the block
        assign lane_word[g] = held_req.ven_lanes[g]
            ? rd_words[held_req.addr_wide[g][2 +: lsc_pkg::N_BLOCK_BITS]]
            : '0;

        lsc_load_extend u_lane_ext (
            .word_in   (lane_word[g]),
            .load_type (held_req.load_type),
            .byte_en   (be_lane[g]),
            .ext_out   (core_resp.dload_ext_wide[g])
        );
    end

    assign core_resp.ready    = ~busy;
    assign core_resp.mal_addr = mal_scalar & ~held_req.block_access;

endmodule

`default_nettype wire

// File: verilog/block_data_mem.sv
// block-wide data memory model with fixed access latency
// also answers icache and dcache flush requests after fixed delays
`timescale 1ns/10ps
`default_nettype none

module block_data_mem (
    input  wire logic                CLK,
    input  wire logic                nRST,
    input  wire lsc_pkg::bus_req_t   bus_req,
    input  wire lsc_pkg::cache_ctl_t cc,
    output lsc_pkg::block_t          rdata,
    output logic                     busy,
    output logic                     iflush_done,
    output logic                     dflush_done
);

    lsc_pkg::block_t                  mem [lsc_pkg::MEM_BLOCKS];
    logic [lsc_pkg::BLOCK_INDEX_BITS-1:0] blk;
    logic [lsc_pkg::MEM_CNT_BITS-1:0] lat_cnt;
    logic [1:0]                       guard;
    logic                             start;
    logic [1:0]                       flush_req;
    logic [1:0]                       flush_done;
    logic [lsc_pkg::FLUSH_CNT_BITS-1:0] flush_cnt [2];

    assign blk   = bus_req.addr[lsc_pkg::N_BLOCK_BITS+2 +: lsc_pkg::BLOCK_INDEX_BITS];
    assign start = (bus_req.ren | bus_req.wen) && (lat_cnt == '0) && (guard == 2'd0);
    assign busy  = (lat_cnt != '0) | start;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lat_cnt <= '0;
            guard   <= 2'd0;
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
            // skip two edges while the input register brings in the next request
            if (lat_cnt == 1) guard <= 2'd2;
        end else if (guard != 2'd0) begin
            guard <= guard - 1'b1;
        end else if (start) begin
            lat_cnt <= lsc_pkg::MEM_CNT_BITS'(lsc_pkg::MEM_LATENCY);
        end
    end

    // access happens on the edge where busy drops
    always_ff @(posedge CLK) begin
        if (lat_cnt == 1) begin
            if (bus_req.wen) begin
                for (int b = 0; b < 4*lsc_pkg::BLOCK_WORDS; b++) begin
                    if (bus_req.byte_en[b]) begin
                        mem[blk][b/4][8*(b%4) +: 8] <= bus_req.wdata[b/4][8*(b%4) +: 8];
                    end
                end
            end
            rdata <= mem[blk];
        end
    end

    assign flush_req   = {cc.dcache_flush, cc.icache_flush};
    assign iflush_done = flush_done[0];
    assign dflush_done = flush_done[1];

    for (genvar f = 0; f < 2; f++) begin : g_flush
        always_ff @(posedge CLK, negedge nRST) begin
            if (!nRST) begin
                flush_cnt[f] <= '0;
            end else if (flush_req[f]) begin
                flush_cnt[f] <= lsc_pkg::FLUSH_CNT_BITS'((f == 0) ? lsc_pkg::IFLUSH_CYCLES
                                                                  : lsc_pkg::DFLUSH_CYCLES);
            end else if (flush_cnt[f] != '0) begin
                flush_cnt[f] <= flush_cnt[f] - 1'b1;
            end
        end
        assign flush_done[f] = (flush_cnt[f] == 1);
    end

endmodule

`default_nettype wire

// File: verilog/lsc_top.sv
// top of the load-store path
// request register, controller, fence tracker and block memory
`timescale 1ns/10ps
`default_nettype none

module lsc_top (
    input  wire logic              CLK,
    input  wire logic              nRST,
    input  wire lsc_pkg::lsc_req_t core_req,
    input  wire logic              ifence,
    output lsc_pkg::lsc_resp_t     core_resp,
    output logic                   fence_stall
);

    lsc_pkg::lsc_req_t   held_req;
    lsc_pkg::bus_req_t   bus_req;
    lsc_pkg::block_t     rdata;
    lsc_pkg::cache_ctl_t cc;
    logic                busy;
    logic                iflush_done;
    logic                dflush_done;

    lsc_req_latch u_req_latch (
        .CLK      (CLK),
        .nRST     (nRST),
        .core_req (core_req),
        .ready    (core_resp.ready),
        .held_req (held_req)
    );

    load_store_controller u_lsc (
        .held_req  (held_req),
        .rdata     (rdata),
        .busy      (busy),
        .bus_req   (bus_req),
        .core_resp (core_resp)
    );

    lsc_fence_tracker u_fence (
        .CLK         (CLK),
        .nRST        (nRST),
        .ifence      (ifence),
        .iflush_done (iflush_done),
        .dflush_done (dflush_done),
        .cc          (cc),
        .fence_stall (fence_stall)
    );

    block_data_mem u_mem (
        .CLK         (CLK),
        .nRST        (nRST),
        .bus_req     (bus_req),
        .cc          (cc),
        .rdata       (rdata),
        .busy        (busy),
        .iflush_done (iflush_done),
        .dflush_done (dflush_done)
    );

endmodule

`default_nettype wire

// File: tests/lsc_props.sv
// concurrent checks on memory latency, held request, flush pulses and fence stall
// bound into lsc_top
`timescale 1ns/10ps
`default_nettype none

module lsc_props (
    input wire logic                CLK,
    input wire logic                nRST,
    input wire logic                busy,
    input wire lsc_pkg::lsc_req_t   held_req,
    input wire lsc_pkg::cache_ctl_t cc,
    input wire logic                iflush_done,
    input wire logic                dflush_done,
    input wire logic                fence_stall
);

    int busy_run;
    int stall_run;

    // length of the current busy and stall runs
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_run  <= 0;
            stall_run <= 0;
        end else begin
            busy_run  <= busy ? busy_run + 1 : 0;
            stall_run <= fence_stall ? stall_run + 1 : 0;
        end
    end

    busy_bounded: assert property (@(posedge CLK) disable iff (!nRST)
        busy_run <= lsc_pkg::MEM_LATENCY + 1)
        else $error("busy stayed high longer than %0d cycles", lsc_pkg::MEM_LATENCY + 1);

    // the request register takes nothing new while the memory is busy
    held_stable_when_busy: assert property (@(posedge CLK) disable iff (!nRST)
        busy |=> $stable(held_req))
        else $error("held request changed while memory busy");

    iflush_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        cc.icache_flush |=> !cc.icache_flush)
        else $error("icache flush request longer than one cycle");

    dflush_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        cc.dcache_flush |=> !cc.dcache_flush)
        else $error("dcache flush request longer than one cycle");

    idone_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        iflush_done |=> !iflush_done)
        else $error("iflush_done longer than one cycle");

    ddone_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        dflush_done |=> !dflush_done)
        else $error("dflush_done longer than one cycle");

    stall_bounded: assert property (@(posedge CLK) disable iff (!nRST)
        stall_run <= lsc_pkg::DFLUSH_CYCLES + 3)
        else $error("fence_stall stayed high longer than %0d cycles", lsc_pkg::DFLUSH_CYCLES + 3);

endmodule

bind lsc_top lsc_props u_props (
    .CLK         (CLK),
    .nRST        (nRST),
    .busy        (busy),
    .held_req    (held_req),
    .cc          (cc),
    .iflush_done (iflush_done),
    .dflush_done (dflush_done),
    .fence_stall (fence_stall)
);

`default_nettype wire

// File: tests/lsc_tb.sv
// testbench for the load-store path
// scalar, block, fence and back-pressure tests against a reference byte memory
`timescale 1ns/10ps
`default_nettype none

module lsc_tb;

    // about 110 accesses of 7 cycles each, plus reset and fence, with wide margin
    localparam int MAX_CYCLES = 4000;
    localparam int DONE_LIMIT = lsc_pkg::MEM_LATENCY + 3;

    logic               CLK;
    logic               nRST;
    logic               ifence;
    lsc_pkg::lsc_req_t  core_req;
    lsc_pkg::lsc_resp_t core_resp;
    logic               fence_stall;

    logic [7:0]         ref_mem [256];
    int                 seed = 81;
    int                 cycles = 0;
    int                 errors = 0;
    int                 test_errors = 0;
    int                 tests_failed = 0;
    lsc_pkg::lsc_resp_t resp;

    lsc_top dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .core_req    (core_req),
        .ifence      (ifence),
        .core_resp   (core_resp),
        .fence_stall (fence_stall)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles before all tests finished", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic lsc_pkg::lsc_req_t scalar_req(logic rd, logic wr,
                                                     lsc_pkg::load_type_e lt,
                                                     logic [7:0] a, lsc_pkg::word_t d);
        lsc_pkg::lsc_req_t r;
        r            = '0;
        r.ren        = rd;
        r.wen        = wr;
        r.load_type  = lt;
        r.addr       = {24'h000000, a};
        r.store_data = d;
        return r;
    endfunction

    // little-endian byte view of the core
    function automatic lsc_pkg::word_t expect_load(logic [7:0] a, lsc_pkg::load_type_e lt);
        logic [15:0] h;
        h = {ref_mem[a + 8'd1], ref_mem[a]};
        case (lt)
            lsc_pkg::LB:  return {{24{ref_mem[a][7]}}, ref_mem[a]};
            lsc_pkg::LBU: return {24'h000000, ref_mem[a]};
            lsc_pkg::LH:  return {{16{h[15]}}, h};
            lsc_pkg::LHU: return {16'h0000, h};
            default:      return {ref_mem[a + 8'd3], ref_mem[a + 8'd2], h};
        endcase
    endfunction

    task automatic ref_store(logic [7:0] a, lsc_pkg::load_type_e lt, lsc_pkg::word_t d);
        ref_mem[a] = d[7:0];
        if (lt != lsc_pkg::LB && lt != lsc_pkg::LBU) begin
            ref_mem[a + 8'd1] = d[15:8];
        end
        if (lt == lsc_pkg::LW) begin
            ref_mem[a + 8'd2] = d[23:16];
            ref_mem[a + 8'd3] = d[31:24];
        end
    endtask

    task automatic check_value(string name, lsc_pkg::word_t exp, lsc_pkg::word_t act);
        assert (act === exp) else begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    // one access; alt replaces the request while the memory is busy
    task automatic run_access(lsc_pkg::lsc_req_t req, logic disturb, lsc_pkg::lsc_req_t alt);
        int waited;
        waited = 0;
        @(posedge CLK);
        core_req <= req;
        @(posedge CLK);
        if (disturb) begin
            @(posedge CLK);
            core_req <= alt;
        end
        @(negedge CLK);
        while (!core_resp.ready && waited < DONE_LIMIT) begin
            @(negedge CLK);
            waited++;
        end
        assert (core_resp.ready) else begin
            $display("access to address %h did not complete in %0d cycles", req.addr, DONE_LIMIT);
            test_errors++;
        end
        resp = core_resp;
        @(posedge CLK);
        core_req <= '0;
    endtask

    task automatic end_test(string name);
        $display("test %-14s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
                 test_errors);
        errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        int                  rnd;
        int                  idx;
        int                  stall_cycles;
        logic [7:0]          a;
        lsc_pkg::word_t      d;
        lsc_pkg::word_t      exp;
        lsc_pkg::load_type_e lts;
        lsc_pkg::load_type_e ltu;
        lsc_pkg::lsc_req_t   r;
        logic                exp_mal;

        nRST     = 1'b0;
        ifence   = 1'b0;
        core_req = '0;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;

        // random stores, then signed and unsigned loads of the same size
        for (int i = 0; i < 24; i++) begin
            rnd   = $random(seed);
            d     = $random(seed);
            d[7]  = i[0];
            d[15] = i[1];
            a     = rnd[7:0];
            if (rnd[9:8] == 2'd0) begin
                lts = lsc_pkg::LB;
                ltu = lsc_pkg::LBU;
            end else if (rnd[9:8] == 2'd1) begin
                lts  = lsc_pkg::LH;
                ltu  = lsc_pkg::LHU;
                a[0] = 1'b0;
            end else begin
                lts    = lsc_pkg::LW;
                ltu    = lsc_pkg::LW;
                a[1:0] = 2'b00;
            end
            run_access(scalar_req(1'b0, 1'b1, lts, a, d), 1'b0, '0);
            ref_store(a, lts, d);
            run_access(scalar_req(1'b1, 1'b0, lts, a, '0), 1'b0, '0);
            check_value("scalar_rt", expect_load(a, lts), resp.dload_ext);
            run_access(scalar_req(1'b1, 1'b0, ltu, a, '0), 1'b0, '0);
            check_value("scalar_rt", expect_load(a, ltu), resp.dload_ext);
        end
        end_test("scalar_rt");

        for (int k = 0; k < 4; k++) begin
            a = 8'h80 + 8'(4 * k);
            d = $random(seed);
            run_access(scalar_req(1'b0, 1'b1, lsc_pkg::LW, a, d), 1'b0, '0);
            ref_store(a, lsc_pkg::LW, d);
            d = $random(seed);
            run_access(scalar_req(1'b0, 1'b1, lsc_pkg::LB, a + 8'(k), d), 1'b0, '0);
            ref_store(a + 8'(k), lsc_pkg::LB, d);
            run_access(scalar_req(1'b1, 1'b0, lsc_pkg::LW, a, '0), 1'b0, '0);
            check_value("partial_store", expect_load(a, lsc_pkg::LW), resp.dload_ext);
        end
        end_test("partial_store");

        for (int k = 0; k < 4; k++) begin
            for (int t = 0; t < 5; t++) begin
                a   = 8'h40 + 8'(k);
                lts = lsc_pkg::load_type_e'(3'(t));
                if (lts == lsc_pkg::LH || lts == lsc_pkg::LHU) begin
                    exp_mal = a[0];
                end else begin
                    exp_mal = (lts == lsc_pkg::LW) && (a[1:0] != 2'b00);
                end
                run_access(scalar_req(1'b1, 1'b0, lts, a, '0), 1'b0, '0);
                check_value("misalign", {31'b0, exp_mal}, {31'b0, resp.mal_addr});
            end
        end
        end_test("misalign");

        // full block store, then a store that skips lane 2
        for (int p = 0; p < 2; p++) begin
            r              = '0;
            r.wen          = 1'b1;
            r.block_access = 1'b1;
            r.load_type    = lsc_pkg::LW;
            r.addr         = 32'h0000_00c7;
            r.ven_lanes    = (p == 0) ? 4'b1111 : 4'b1011;
            for (int g = 0; g < lsc_pkg::NUM_LANES; g++) begin
                r.store_data_wide[g] = $random(seed);
                if (r.ven_lanes[g]) begin
                    ref_store(8'hc0 + 8'(4 * g), lsc_pkg::LW, r.store_data_wide[g]);
                end
            end
            run_access(r, 1'b0, '0);
        end
        // shuffled load with lane 1 off, then an identity load of all lanes
        for (int p = 0; p < 2; p++) begin
            r              = '0;
            r.ren          = 1'b1;
            r.block_access = 1'b1;
            r.load_type    = lsc_pkg::LW;
            r.addr         = 32'h0000_00cb;
            r.ven_lanes    = (p == 0) ? 4'b1101 : 4'b1111;
            for (int g = 0; g < lsc_pkg::NUM_LANES; g++) begin
                r.addr_wide[g] = 32'h0000_00c0 + 32'(4 * ((p == 0) ? (3 * g + 2) % 4 : g));
            end
            run_access(r, 1'b0, '0);
            for (int g = 0; g < lsc_pkg::NUM_LANES; g++) begin
                idx = (p == 0) ? (3 * g + 2) % 4 : g;
                exp = r.ven_lanes[g] ? expect_load(8'hc0 + 8'(4 * idx), lsc_pkg::LW) : '0;
                check_value("block", exp, resp.dload_ext_wide[g]);
            end
        end
        end_test("block");

        @(posedge CLK);
        ifence <= 1'b1;
        @(negedge CLK);
        @(negedge CLK);
        stall_cycles = 1;
        assert (fence_stall) else begin
            $display("fence_stall did not rise after ifence went high");
            test_errors++;
        end
        while (fence_stall && stall_cycles <= lsc_pkg::DFLUSH_CYCLES + 3) begin
            @(negedge CLK);
            stall_cycles++;
        end
        assert (!fence_stall) else begin
            $display("fence_stall still high after %0d cycles", stall_cycles);
            test_errors++;
        end
        // ifence held high must not start another flush
        repeat (12) begin
            @(negedge CLK);
            assert (!fence_stall) else begin
                $display("fence_stall rose again while ifence stayed high");
                test_errors++;
            end
        end
        @(posedge CLK);
        ifence <= 1'b0;
        end_test("fence");

        a = 8'hb4;
        d = $random(seed);
        run_access(scalar_req(1'b0, 1'b1, lsc_pkg::LW, a, d), 1'b0, '0);
        ref_store(a, lsc_pkg::LW, d);
        run_access(scalar_req(1'b1, 1'b0, lsc_pkg::LW, a, '0), 1'b1,
                   scalar_req(1'b0, 1'b1, lsc_pkg::LW, a, ~d));
        check_value("backpressure", expect_load(a, lsc_pkg::LW), resp.dload_ext);
        d = $random(seed);
        run_access(scalar_req(1'b0, 1'b1, lsc_pkg::LW, a, d), 1'b1,
                   scalar_req(1'b0, 1'b1, lsc_pkg::LW, a, ~d));
        ref_store(a, lsc_pkg::LW, d);
        run_access(scalar_req(1'b1, 1'b0, lsc_pkg::LW, a, '0), 1'b0, '0);
        check_value("backpressure", expect_load(a, lsc_pkg::LW), resp.dload_ext);
        end_test("backpressure");

        $display("tests run 6, tests failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/lsc_pkg.sv
verilog/lsc_req_latch.sv
verilog/lsc_byte_lane.sv
verilog/lsc_load_extend.sv
verilog/lsc_fence_tracker.sv
verilog/load_store_controller.sv
verilog/block_data_mem.sv
verilog/lsc_top.sv
tests/lsc_props.sv
tests/lsc_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the load-store path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='*** FAILED ***'

verilator --binary --timing --assert -Wno-fatal --top-module lsc_tb \
    -f verilog.f -o lsc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/lsc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "$FAIL_MSG" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0
